/* hdl/lsu_ctrl_pkg.sv */
/*
  lsu central control definitions
  issue-queue size, cp0 field widths and the packed status bundles
  shared by the load/store control blocks
*/
package lsu_ctrl_pkg;

  // ========================================================================
  // sizes
  // ========================================================================
  localparam int LSIQ_ENTRY  = 12;
  localparam int PREF_DIST_W = 2;
  // one-hot select, bit n set for field value n (1x, 2x, 4x, 8x)
  localparam int DIST_SEL_W  = 4;

  // one bit per load/store issue-queue entry
  typedef logic [LSIQ_ENTRY-1:0] lsiq_vec_t;

  // ========================================================================
  // per-pipe status bundles
  // ========================================================================
  // da stage feedback of one pipe
  typedef struct packed {
    lsiq_vec_t wait_fence;
    lsiq_vec_t rb_full;
    lsiq_vec_t already_da;
    lsiq_vec_t secd;
    lsiq_vec_t spec_fail;
    lsiq_vec_t bkpta_data;
    lsiq_vec_t bkptb_data;
    lsiq_vec_t boundary;
    lsiq_vec_t pop_entry;
    lsiq_vec_t ecc_wakeup;
    logic      pop_vld;
  } pipe_da_status_t;

  // dc stage feedback, full is lq full on ld pipe and sq full on st pipe
  typedef struct packed {
    lsiq_vec_t tlb_busy;
    lsiq_vec_t full;
    lsiq_vec_t imme_wakeup;
  } pipe_dc_status_t;

  // rf stage restart request
  typedef struct packed {
    logic      sel;
    logic      stall_ori;
    lsiq_vec_t restart_entry;
  } pipe_rf_restart_t;

  // buffer empty flags for idle detection
  typedef struct packed {
    logic wmb_empty;
    logic wmb_no_op;
    logic sq_empty;
    logic rb_empty;
    logic lfb_empty;
    logic vmb_empty;
    logic vb_empty;
  } buf_empty_t;

  // ========================================================================
  // performance counter events
  // ========================================================================
  typedef struct packed {
    logic ld_cache_access;
    logic ld_cache_miss;
    logic st_cache_access;
    logic st_cache_miss;
    logic ld_discard_sq;
    logic ld_data_discard;
    logic ld_cross_4k_stall;
    logic ld_other_stall;
    logic st_cross_4k_stall;
    logic st_other_stall;
    logic ld_unalign;
    logic st_unalign;
  } hpcp_raw_t;

  typedef struct packed {
    logic       cache_read_access;
    logic       cache_read_miss;
    logic       cache_write_access;
    logic       cache_write_miss;
    logic       replay_discard_sq;
    logic       replay_data_discard;
    logic       ld_stall_cross_4k;
    logic       ld_stall_other;
    logic       st_stall_cross_4k;
    logic       st_stall_other;
    logic       fence_stall;
    // count of unaligned insts this cycle, 0 to 2
    logic [1:0] unalign_inst;
  } hpcp_evt_t;

endpackage

/* hdl/lsu_ctrl_top.sv */
/*
  load/store unit central control
  prefetch distance selects, performance events and issue-queue feedback
*/
`timescale 1ns/10ps

module lsu_ctrl_top
  import lsu_ctrl_pkg::*;
(
  input  logic                   cp0_lsu_clk,
  input  logic                   cpurst_b,
  // cp0 and performance counter
  input  logic [PREF_DIST_W-1:0] cp0_dcache_pref_dist,
  input  logic [PREF_DIST_W-1:0] cp0_l2_pref_dist,
  input  logic                   hpcp_cnt_en,
  input  hpcp_raw_t              hpcp_raw,
  input  logic                   lsu_has_fence,
  input  logic                   ld_ag_inst_vld,
  input  logic                   st_ag_inst_vld,
  input  logic                   ld_da_inst_vld,
  input  logic                   st_da_inst_vld,
  // pipe status
  input  pipe_rf_restart_t       ld_rf,
  input  pipe_rf_restart_t       st_rf,
  input  pipe_dc_status_t        ld_dc,
  input  pipe_dc_status_t        st_dc,
  input  pipe_da_status_t        ld_da,
  input  pipe_da_status_t        st_da,
  input  lsiq_vec_t              depd_wakeup_sq_global,
  input  lsiq_vec_t              depd_wakeup_sq_data,
  input  lsiq_vec_t              depd_wakeup_wmb,
  input  lsiq_vec_t              depd_wakeup_lfb,
  input  lsiq_vec_t              mmu_tlb_wakeup,
  input  lsiq_vec_t              ld_ag_wait_old,
  input  lsiq_vec_t              st_ag_wait_old,
  input  lsiq_vec_t              ld_da_wait_old,
  input  buf_empty_t             buf_empty,
  // to prefetch unit and counters
  output logic [DIST_SEL_W-1:0]  lsu_pfu_l1_dist_sel,
  output logic [DIST_SEL_W-1:0]  lsu_pfu_l2_dist_sel,
  output hpcp_evt_t              lsu_hpcp_evt,
  // to issue queue
  output lsiq_vec_t              idu_tlb_busy,
  output lsiq_vec_t              idu_lq_full,
  output lsiq_vec_t              idu_sq_full,
  output lsiq_vec_t              idu_wait_fence,
  output lsiq_vec_t              idu_rb_full,
  output lsiq_vec_t              idu_already_da,
  output lsiq_vec_t              idu_unalign,
  output lsiq_vec_t              idu_secd,
  output lsiq_vec_t              idu_spec_fail,
  output lsiq_vec_t              idu_bkpta_data,
  output lsiq_vec_t              idu_bkptb_data,
  output logic                   lsiq_pop_vld,
  output logic                   lsiq_pop0_vld,
  output logic                   lsiq_pop1_vld,
  output lsiq_vec_t              lsiq_pop_entry,
  output lsiq_vec_t              idu_wakeup,
  output lsiq_vec_t              idu_tlb_wakeup,
  output lsiq_vec_t              idu_wait_old,
  output logic                   lsu_no_op,
  output logic                   lsu_had_no_op
);

  // ========================================================================
  // side blocks
  // ========================================================================
  lsu_pref_dist_ctrl u_pref_dist_ctrl (
    .cp0_lsu_clk          (cp0_lsu_clk),
    .cpurst_b             (cpurst_b),
    .cp0_dcache_pref_dist (cp0_dcache_pref_dist),
    .cp0_l2_pref_dist     (cp0_l2_pref_dist),
    .l1_dist_sel          (lsu_pfu_l1_dist_sel),
    .l2_dist_sel          (lsu_pfu_l2_dist_sel)
  );

  lsu_hpcp_event_reg u_hpcp_event_reg (
    .cp0_lsu_clk    (cp0_lsu_clk),
    .cpurst_b       (cpurst_b),
    .hpcp_cnt_en    (hpcp_cnt_en),
    .hpcp_raw       (hpcp_raw),
    .lsu_has_fence  (lsu_has_fence),
    .ld_ag_inst_vld (ld_ag_inst_vld),
    .st_ag_inst_vld (st_ag_inst_vld),
    .ld_da_inst_vld (ld_da_inst_vld),
    .st_da_inst_vld (st_da_inst_vld),
    .hpcp_evt       (lsu_hpcp_evt)
  );

  // combinational, same cycle as the pipe status
  lsu_iq_feedback u_iq_feedback (
    .ld_rf                 (ld_rf),
    .st_rf                 (st_rf),
    .ld_dc                 (ld_dc),
    .st_dc                 (st_dc),
    .ld_da                 (ld_da),
    .st_da                 (st_da),
    .depd_wakeup_sq_global (depd_wakeup_sq_global),
    .depd_wakeup_sq_data   (depd_wakeup_sq_data),
    .depd_wakeup_wmb       (depd_wakeup_wmb),
    .depd_wakeup_lfb       (depd_wakeup_lfb),
    .mmu_tlb_wakeup        (mmu_tlb_wakeup),
    .ld_ag_wait_old        (ld_ag_wait_old),
    .st_ag_wait_old        (st_ag_wait_old),
    .ld_da_wait_old        (ld_da_wait_old),
    .buf_empty             (buf_empty),
    .idu_tlb_busy          (idu_tlb_busy),
    .idu_lq_full           (idu_lq_full),
    .idu_sq_full           (idu_sq_full),
    .idu_wait_fence        (idu_wait_fence),
    .idu_rb_full           (idu_rb_full),
    .idu_already_da        (idu_already_da),
    .idu_unalign           (idu_unalign),
    .idu_secd              (idu_secd),
    .idu_spec_fail         (idu_spec_fail),
    .idu_bkpta_data        (idu_bkpta_data),
    .idu_bkptb_data        (idu_bkptb_data),
    .lsiq_pop_vld          (lsiq_pop_vld),
    .lsiq_pop0_vld         (lsiq_pop0_vld),
    .lsiq_pop1_vld         (lsiq_pop1_vld),
    .lsiq_pop_entry        (lsiq_pop_entry),
    .idu_wakeup            (idu_wakeup),
    .idu_tlb_wakeup        (idu_tlb_wakeup),
    .idu_wait_old          (idu_wait_old),
    .lsu_no_op             (lsu_no_op),
    .lsu_had_no_op         (lsu_had_no_op)
  );

endmodule

/* hdl/lsu_hpcp_event_reg.sv */
/*
  performance counter event register
  samples the load/store raw events while counting is enabled and the
  unit is active, and sums the unaligned flags of both pipes
*/
`timescale 1ns/10ps

module lsu_hpcp_event_reg
  import lsu_ctrl_pkg::*;
(
  input  logic      cp0_lsu_clk,
  input  logic      cpurst_b,
  input  logic      hpcp_cnt_en,
  input  hpcp_raw_t hpcp_raw,
  input  logic      lsu_has_fence,
  input  logic      ld_ag_inst_vld,
  input  logic      st_ag_inst_vld,
  input  logic      ld_da_inst_vld,
  input  logic      st_da_inst_vld,
  output hpcp_evt_t hpcp_evt
);

  hpcp_evt_t hpcp_nxt;
  logic      pipe_active;
  logic      evt_pending;
  logic      hpcp_up_vld;

  // ========================================================================
  // update condition
  // ========================================================================
  assign pipe_active = ld_ag_inst_vld
                    || st_ag_inst_vld
                    || ld_da_inst_vld
                    || st_da_inst_vld
                    || lsu_has_fence;

  // keep sampling until the last event flushes back to zero
  assign evt_pending = (|hpcp_raw) || (|hpcp_evt);

  assign hpcp_up_vld = hpcp_cnt_en && (pipe_active || evt_pending);

  // ========================================================================
  // event mapping
  // ========================================================================
  always_comb
  begin
    hpcp_nxt.cache_read_access   = hpcp_raw.ld_cache_access;
    hpcp_nxt.cache_read_miss     = hpcp_raw.ld_cache_miss;
    hpcp_nxt.cache_write_access  = hpcp_raw.st_cache_access;
    hpcp_nxt.cache_write_miss    = hpcp_raw.st_cache_miss;
    hpcp_nxt.replay_discard_sq   = hpcp_raw.ld_discard_sq;
    hpcp_nxt.replay_data_discard = hpcp_raw.ld_data_discard;
    hpcp_nxt.ld_stall_cross_4k   = hpcp_raw.ld_cross_4k_stall;
    hpcp_nxt.ld_stall_other      = hpcp_raw.ld_other_stall;
    hpcp_nxt.st_stall_cross_4k   = hpcp_raw.st_cross_4k_stall;
    hpcp_nxt.st_stall_other      = hpcp_raw.st_other_stall;
    hpcp_nxt.fence_stall         = lsu_has_fence;
    // ld and st can both be unaligned in one cycle
    hpcp_nxt.unalign_inst        = {1'b0, hpcp_raw.ld_unalign}
                                 + {1'b0, hpcp_raw.st_unalign};
  end

  // ========================================================================
  // event register
  // ========================================================================
  always_ff @(posedge cp0_lsu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      hpcp_evt <= '0;
    end
    else if (hpcp_up_vld)
    begin
      hpcp_evt <= hpcp_nxt;
    end
  end

  // two pipes give at most two unaligned insts
  a_unalign_max2: assert property (
    @(posedge cp0_lsu_clk) disable iff (!cpurst_b)
    hpcp_evt.unalign_inst != 2'b11
  ) else $error("unaligned inst count above two");

endmodule

/* hdl/lsu_iq_feedback.sv */
/*
  issue-queue feedback merge
  folds load and store pipe status into one set of lsiq vectors,
  builds the wakeup and pop signals and flags an idle unit
*/
`timescale 1ns/10ps

module lsu_iq_feedback
  import lsu_ctrl_pkg::*;
(
  input  pipe_rf_restart_t ld_rf,
  input  pipe_rf_restart_t st_rf,
  input  pipe_dc_status_t  ld_dc,
  input  pipe_dc_status_t  st_dc,
  input  pipe_da_status_t  ld_da,
  input  pipe_da_status_t  st_da,
  input  lsiq_vec_t        depd_wakeup_sq_global,
  input  lsiq_vec_t        depd_wakeup_sq_data,
  input  lsiq_vec_t        depd_wakeup_wmb,
  input  lsiq_vec_t        depd_wakeup_lfb,
  input  lsiq_vec_t        mmu_tlb_wakeup,
  input  lsiq_vec_t        ld_ag_wait_old,
  input  lsiq_vec_t        st_ag_wait_old,
  input  lsiq_vec_t        ld_da_wait_old,
  input  buf_empty_t       buf_empty,
  output lsiq_vec_t        idu_tlb_busy,
  output lsiq_vec_t        idu_lq_full,
  output lsiq_vec_t        idu_sq_full,
  output lsiq_vec_t        idu_wait_fence,
  output lsiq_vec_t        idu_rb_full,
  output lsiq_vec_t        idu_already_da,
  output lsiq_vec_t        idu_unalign,
  output lsiq_vec_t        idu_secd,
  output lsiq_vec_t        idu_spec_fail,
  output lsiq_vec_t        idu_bkpta_data,
  output lsiq_vec_t        idu_bkptb_data,
  output logic             lsiq_pop_vld,
  output logic             lsiq_pop0_vld,
  output logic             lsiq_pop1_vld,
  output lsiq_vec_t        lsiq_pop_entry,
  output lsiq_vec_t        idu_wakeup,
  output lsiq_vec_t        idu_tlb_wakeup,
  output lsiq_vec_t        idu_wait_old,
  output logic             lsu_no_op,
  output logic             lsu_had_no_op
);

  lsiq_vec_t ld_rf_wakeup;
  lsiq_vec_t st_rf_wakeup;
  logic      other_bufs_empty;

  // ========================================================================
  // pipe status merge
  // ========================================================================
  assign idu_tlb_busy   = ld_dc.tlb_busy   | st_dc.tlb_busy;
  // full vectors are owned by one pipe each
  assign idu_lq_full    = ld_dc.full;
  assign idu_sq_full    = st_dc.full;
  assign idu_wait_fence = ld_da.wait_fence | st_da.wait_fence;
  assign idu_rb_full    = ld_da.rb_full    | st_da.rb_full;
  assign idu_already_da = ld_da.already_da | st_da.already_da;
  assign idu_unalign    = ld_da.boundary   | st_da.boundary;
  assign idu_secd       = ld_da.secd       | st_da.secd;
  assign idu_spec_fail  = ld_da.spec_fail  | st_da.spec_fail;
  assign idu_bkpta_data = ld_da.bkpta_data | st_da.bkpta_data;
  assign idu_bkptb_data = ld_da.bkptb_data | st_da.bkptb_data;

  // pop0 is the ld pipe, pop1 the st pipe
  assign lsiq_pop_vld   = ld_da.pop_vld | st_da.pop_vld;
  assign lsiq_pop0_vld  = ld_da.pop_vld;
  assign lsiq_pop1_vld  = st_da.pop_vld;
  assign lsiq_pop_entry = ld_da.pop_entry | st_da.pop_entry;

  // ========================================================================
  // wakeup
  // ========================================================================
  // rf restart only counts when the pipe was selected and stalled
  assign ld_rf_wakeup = ld_rf.restart_entry & {LSIQ_ENTRY{ld_rf.sel & ld_rf.stall_ori}};
  assign st_rf_wakeup = st_rf.restart_entry & {LSIQ_ENTRY{st_rf.sel & st_rf.stall_ori}};

  assign idu_wakeup = ld_rf_wakeup
                    | st_rf_wakeup
                    | ld_dc.imme_wakeup
                    | st_dc.imme_wakeup
                    | ld_da.secd
                    | ld_da.ecc_wakeup
                    | st_da.secd
                    | st_da.ecc_wakeup
                    | depd_wakeup_sq_global
                    | depd_wakeup_sq_data
                    | depd_wakeup_wmb
                    | depd_wakeup_lfb;

  assign idu_tlb_wakeup = mmu_tlb_wakeup;
  assign idu_wait_old   = ld_ag_wait_old | st_ag_wait_old | ld_da_wait_old;

  // ========================================================================
  // idle detection
  // ========================================================================
  assign other_bufs_empty = buf_empty.sq_empty
                         && buf_empty.rb_empty
                         && buf_empty.lfb_empty
                         && buf_empty.vmb_empty
                         && buf_empty.vb_empty;

  assign lsu_no_op     = buf_empty.wmb_empty && other_bufs_empty;
  // debug view only needs the wmb to have no outstanding op
  assign lsu_had_no_op = buf_empty.wmb_no_op && other_bufs_empty;

  // da stages must not name an entry without a pop
  always_comb
  begin
    a_pop_entry_vld: assert final (lsiq_pop_vld || (lsiq_pop_entry == '0))
      else $error("lsiq pop entry set without pop valid");
  end

endmodule

/* hdl/lsu_pref_dist_ctrl.sv */
/*
  prefetch distance control
  decodes the cp0 l1 and l2 prefetch distance fields into one-hot
  selects and holds them in registers for the prefetch unit
*/
`timescale 1ns/10ps

module lsu_pref_dist_ctrl
  import lsu_ctrl_pkg::*;
(
  input  logic                   cp0_lsu_clk,
  input  logic                   cpurst_b,
  input  logic [PREF_DIST_W-1:0] cp0_dcache_pref_dist,
  input  logic [PREF_DIST_W-1:0] cp0_l2_pref_dist,
  output logic [DIST_SEL_W-1:0]  l1_dist_sel,
  output logic [DIST_SEL_W-1:0]  l2_dist_sel
);

  logic [DIST_SEL_W-1:0] l1_dist_dec;
  logic [DIST_SEL_W-1:0] l2_dist_dec;
  logic                  dist_up;

  // ========================================================================
  // field decode
  // ========================================================================
  // value n sets bit n, so 0 is 1x and 3 is 8x
  assign l1_dist_dec = DIST_SEL_W'(1) << cp0_dcache_pref_dist;
  assign l2_dist_dec = DIST_SEL_W'(1) << cp0_l2_pref_dist;

  // only load when either decode moved
  assign dist_up = (l1_dist_dec != l1_dist_sel)
                || (l2_dist_dec != l2_dist_sel);

  // ========================================================================
  // select registers
  // ========================================================================
  always_ff @(posedge cp0_lsu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      l1_dist_sel <= '0;
      l2_dist_sel <= '0;
    end
    else if (dist_up)
    begin
      l1_dist_sel <= l1_dist_dec;
      l2_dist_sel <= l2_dist_dec;
    end
  end

  // selects leave reset at zero and only ever take a decoded value
  a_dist_sel_onehot0: assert property (
    @(posedge cp0_lsu_clk) disable iff (!cpurst_b)
    $onehot0(l1_dist_sel) && $onehot0(l2_dist_sel)
  ) else $error("prefetch distance select is not one-hot");

endmodule

/* project.f */
+incdir+include
hdl/lsu_ctrl_pkg.sv
hdl/lsu_pref_dist_ctrl.sv
hdl/lsu_hpcp_event_reg.sv
hdl/lsu_iq_feedback.sv
hdl/lsu_ctrl_top.sv
verif/lsu_ctrl_tb.sv

/* include/lsu_ctrl_tb_ref.svh */
/*
  reference model for the lsu central control testbench
  expected outputs worked out from the block rules, and compare tasks
  typed to the dut result kinds
*/
`ifndef LSU_CTRL_TB_REF_SVH
`define LSU_CTRL_TB_REF_SVH

// ==========================================================================
// reference functions
// ==========================================================================
// field value n selects 1x, 2x, 4x or 8x
function automatic logic [DIST_SEL_W-1:0] ref_dist_sel(input logic [PREF_DIST_W-1:0] field);
  case (field)
    2'd0:    return 4'b0001;
    2'd1:    return 4'b0010;
    2'd2:    return 4'b0100;
    default: return 4'b1000;
  endcase
endfunction

function automatic hpcp_evt_t ref_hpcp_evt(input hpcp_raw_t raw, input logic fence);
  hpcp_evt_t e;
  e.cache_read_access   = raw.ld_cache_access;
  e.cache_read_miss     = raw.ld_cache_miss;
  e.cache_write_access  = raw.st_cache_access;
  e.cache_write_miss    = raw.st_cache_miss;
  e.replay_discard_sq   = raw.ld_discard_sq;
  e.replay_data_discard = raw.ld_data_discard;
  e.ld_stall_cross_4k   = raw.ld_cross_4k_stall;
  e.ld_stall_other      = raw.ld_other_stall;
  e.st_stall_cross_4k   = raw.st_cross_4k_stall;
  e.st_stall_other      = raw.st_other_stall;
  e.fence_stall         = fence;
  // count of set unaligned flags
  e.unalign_inst        = 2'd0;
  if (raw.ld_unalign)
    e.unalign_inst = e.unalign_inst + 2'd1;
  if (raw.st_unalign)
    e.unalign_inst = e.unalign_inst + 2'd1;
  return e;
endfunction

// load on enable plus any activity, raw event or live event bit
function automatic logic ref_evt_update(input logic cnt_en, input logic active,
                                        input hpcp_raw_t raw, input hpcp_evt_t cur);
  return cnt_en && (active || (raw != '0) || (cur != '0));
endfunction

function automatic lsiq_vec_t ref_rf_wakeup(input pipe_rf_restart_t rf);
  if (rf.sel && rf.stall_ori)
    return rf.restart_entry;
  return '0;
endfunction

function automatic lsiq_vec_t ref_wakeup(input pipe_rf_restart_t ld_r, input pipe_rf_restart_t st_r,
                                         input pipe_dc_status_t ld_c, input pipe_dc_status_t st_c,
                                         input pipe_da_status_t ld_a, input pipe_da_status_t st_a,
                                         input lsiq_vec_t depd_any);
  return ref_rf_wakeup(ld_r) | ref_rf_wakeup(st_r) | ld_c.imme_wakeup | st_c.imme_wakeup
       | ld_a.secd | ld_a.ecc_wakeup | st_a.secd | st_a.ecc_wakeup | depd_any;
endfunction

function automatic logic ref_no_op(input buf_empty_t b);
  return b.wmb_empty && b.sq_empty && b.rb_empty && b.lfb_empty && b.vmb_empty && b.vb_empty;
endfunction

function automatic logic ref_had_no_op(input buf_empty_t b);
  return b.wmb_no_op && b.sq_empty && b.rb_empty && b.lfb_empty && b.vmb_empty && b.vb_empty;
endfunction

// ==========================================================================
// compare tasks
// ==========================================================================
task automatic check_vec(input string name, input lsiq_vec_t got, input lsiq_vec_t exp);
  if (got !== exp)
    report_failure($sformatf("[ERROR] %0t %s got %h expected %h", $time, name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp)
    report_failure($sformatf("[ERROR] %0t %s got %b expected %b", $time, name, got, exp));
endtask

task automatic check_sel(input string name, input logic [DIST_SEL_W-1:0] got,
                         input logic [DIST_SEL_W-1:0] exp);
  if (got !== exp)
    report_failure($sformatf("[ERROR] %0t %s got %b expected %b", $time, name, got, exp));
endtask

task automatic check_evt(input string name, input hpcp_evt_t got, input hpcp_evt_t exp);
  if (got !== exp)
    report_failure($sformatf("[ERROR] %0t %s got %h expected %h", $time, name, got, exp));
endtask

`endif

/* verif/lsu_ctrl_tb.sv */
/*
  testbench for the lsu central control block
  random pipe status and cp0 fields, then directed cases, with every
  output compared each cycle against a reference model
*/
`timescale 1ns/10ps

module lsu_ctrl_tb
  import lsu_ctrl_pkg::*;
();

  localparam int RANDOM_CYCLES = 2000;
  localparam int CYCLE_LIMIT   = 2500;

  logic                   cp0_lsu_clk;
  logic                   cpurst_b;
  logic [PREF_DIST_W-1:0] cp0_dcache_pref_dist;
  logic [PREF_DIST_W-1:0] cp0_l2_pref_dist;
  logic                   hpcp_cnt_en;
  hpcp_raw_t              hpcp_raw;
  logic                   lsu_has_fence;
  logic                   ld_ag_inst_vld, st_ag_inst_vld, ld_da_inst_vld, st_da_inst_vld;
  pipe_rf_restart_t       ld_rf, st_rf;
  pipe_dc_status_t        ld_dc, st_dc;
  pipe_da_status_t        ld_da, st_da;
  lsiq_vec_t              depd_wakeup_sq_global, depd_wakeup_sq_data;
  lsiq_vec_t              depd_wakeup_wmb, depd_wakeup_lfb, mmu_tlb_wakeup;
  lsiq_vec_t              ld_ag_wait_old, st_ag_wait_old, ld_da_wait_old;
  buf_empty_t             buf_empty;
  // dut outputs
  logic [DIST_SEL_W-1:0]  lsu_pfu_l1_dist_sel, lsu_pfu_l2_dist_sel;
  hpcp_evt_t              lsu_hpcp_evt;
  lsiq_vec_t              idu_tlb_busy, idu_lq_full, idu_sq_full, idu_wait_fence;
  lsiq_vec_t              idu_rb_full, idu_already_da, idu_unalign, idu_secd;
  lsiq_vec_t              idu_spec_fail, idu_bkpta_data, idu_bkptb_data, lsiq_pop_entry;
  lsiq_vec_t              idu_wakeup, idu_tlb_wakeup, idu_wait_old;
  logic                   lsiq_pop_vld, lsiq_pop0_vld, lsiq_pop1_vld;
  logic                   lsu_no_op, lsu_had_no_op;

  // model registers
  logic [DIST_SEL_W-1:0]  model_l1_sel = '0;
  logic [DIST_SEL_W-1:0]  model_l2_sel = '0;
  hpcp_evt_t              model_evt    = '0;
  int                     cycle_count  = 0;
  int                     error_count  = 0;

  lsu_ctrl_top lsu_ctrl_top_i (.*);

  task automatic report_failure(input string what);
    error_count++;
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at the first failure");
  endtask

  `include "lsu_ctrl_tb_ref.svh"

  // ========================================================================
  // random stimulus
  // ========================================================================
  // about one in four
  function automatic logic rand_bit();
    return ($urandom_range(3) == 0);
  endfunction

  function automatic lsiq_vec_t rand_vec();
    lsiq_vec_t v;
    for (int i = 0; i < LSIQ_ENTRY; i++)
      v[i] = rand_bit();
    return v;
  endfunction

  function automatic hpcp_raw_t rand_raw();
    logic [$bits(hpcp_raw_t)-1:0] r;
    for (int i = 0; i < $bits(hpcp_raw_t); i++)
      r[i] = rand_bit();
    return hpcp_raw_t'(r);
  endfunction

  function automatic pipe_da_status_t rand_da();
    pipe_da_status_t d;
    d.wait_fence = rand_vec();
    d.rb_full    = rand_vec();
    d.already_da = rand_vec();
    d.secd       = rand_vec();
    d.spec_fail  = rand_vec();
    d.bkpta_data = rand_vec();
    d.bkptb_data = rand_vec();
    d.boundary   = rand_vec();
    d.ecc_wakeup = rand_vec();
    d.pop_vld    = rand_bit();
    // no pop entry without a pop
    d.pop_entry  = d.pop_vld ? rand_vec() : '0;
    return d;
  endfunction

  function automatic pipe_dc_status_t rand_dc();
    pipe_dc_status_t c;
    c.tlb_busy    = rand_vec();
    c.full        = rand_vec();
    c.imme_wakeup = rand_vec();
    return c;
  endfunction

  function automatic pipe_rf_restart_t rand_rf();
    pipe_rf_restart_t r;
    r.sel           = rand_bit();
    r.stall_ori     = rand_bit();
    r.restart_entry = rand_vec();
    return r;
  endfunction

  // empties mostly high so idle shows up often
  function automatic buf_empty_t rand_empty();
    logic [$bits(buf_empty_t)-1:0] e;
    for (int i = 0; i < $bits(buf_empty_t); i++)
      e[i] = ($urandom_range(7) != 0);
    return buf_empty_t'(e);
  endfunction

  task automatic drive_random();
    cp0_dcache_pref_dist  <= PREF_DIST_W'($urandom_range(3));
    cp0_l2_pref_dist      <= PREF_DIST_W'($urandom_range(3));
    hpcp_cnt_en           <= ($urandom_range(3) != 0);
    hpcp_raw              <= rand_raw();
    lsu_has_fence         <= rand_bit();
    ld_ag_inst_vld        <= rand_bit();
    st_ag_inst_vld        <= rand_bit();
    ld_da_inst_vld        <= rand_bit();
    st_da_inst_vld        <= rand_bit();
    ld_rf                 <= rand_rf();
    st_rf                 <= rand_rf();
    ld_dc                 <= rand_dc();
    st_dc                 <= rand_dc();
    ld_da                 <= rand_da();
    st_da                 <= rand_da();
    depd_wakeup_sq_global <= rand_vec();
    depd_wakeup_sq_data   <= rand_vec();
    depd_wakeup_wmb       <= rand_vec();
    depd_wakeup_lfb       <= rand_vec();
    mmu_tlb_wakeup        <= rand_vec();
    ld_ag_wait_old        <= rand_vec();
    st_ag_wait_old        <= rand_vec();
    ld_da_wait_old        <= rand_vec();
    buf_empty             <= rand_empty();
  endtask

  // all pipes idle, all buffers empty, counting off
  task automatic quiet_inputs();
    cp0_dcache_pref_dist  <= '0;
    cp0_l2_pref_dist      <= '0;
    hpcp_cnt_en           <= 1'b0;
    hpcp_raw              <= '0;
    lsu_has_fence         <= 1'b0;
    ld_ag_inst_vld        <= 1'b0;
    st_ag_inst_vld        <= 1'b0;
    ld_da_inst_vld        <= 1'b0;
    st_da_inst_vld        <= 1'b0;
    ld_rf                 <= '0;
    st_rf                 <= '0;
    ld_dc                 <= '0;
    st_dc                 <= '0;
    ld_da                 <= '0;
    st_da                 <= '0;
    depd_wakeup_sq_global <= '0;
    depd_wakeup_sq_data   <= '0;
    depd_wakeup_wmb       <= '0;
    depd_wakeup_lfb       <= '0;
    mmu_tlb_wakeup        <= '0;
    ld_ag_wait_old        <= '0;
    st_ag_wait_old        <= '0;
    ld_da_wait_old        <= '0;
    buf_empty             <= '1;
  endtask

  // ========================================================================
  // reference registers and comparison
  // ========================================================================
  always @(posedge cp0_lsu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      model_l1_sel = '0;
      model_l2_sel = '0;
      model_evt    = '0;
    end
    else
    begin
      model_l1_sel = ref_dist_sel(cp0_dcache_pref_dist);
      model_l2_sel = ref_dist_sel(cp0_l2_pref_dist);
      if (ref_evt_update(hpcp_cnt_en, ld_ag_inst_vld || st_ag_inst_vld || ld_da_inst_vld
                         || st_da_inst_vld || lsu_has_fence, hpcp_raw, model_evt))
        model_evt = ref_hpcp_evt(hpcp_raw, lsu_has_fence);
    end
  end

  task automatic compare_outputs();
    lsiq_vec_t depd_any;
    depd_any = depd_wakeup_sq_global | depd_wakeup_sq_data | depd_wakeup_wmb | depd_wakeup_lfb;
    check_sel("lsu_pfu_l1_dist_sel", lsu_pfu_l1_dist_sel, model_l1_sel);
    check_sel("lsu_pfu_l2_dist_sel", lsu_pfu_l2_dist_sel, model_l2_sel);
    check_evt("lsu_hpcp_evt", lsu_hpcp_evt, model_evt);
    check_vec("idu_tlb_busy", idu_tlb_busy, ld_dc.tlb_busy | st_dc.tlb_busy);
    check_vec("idu_lq_full", idu_lq_full, ld_dc.full);
    check_vec("idu_sq_full", idu_sq_full, st_dc.full);
    check_vec("idu_wait_fence", idu_wait_fence, ld_da.wait_fence | st_da.wait_fence);
    check_vec("idu_rb_full", idu_rb_full, ld_da.rb_full | st_da.rb_full);
    check_vec("idu_already_da", idu_already_da, ld_da.already_da | st_da.already_da);
    check_vec("idu_unalign", idu_unalign, ld_da.boundary | st_da.boundary);
    check_vec("idu_secd", idu_secd, ld_da.secd | st_da.secd);
    check_vec("idu_spec_fail", idu_spec_fail, ld_da.spec_fail | st_da.spec_fail);
    check_vec("idu_bkpta_data", idu_bkpta_data, ld_da.bkpta_data | st_da.bkpta_data);
    check_vec("idu_bkptb_data", idu_bkptb_data, ld_da.bkptb_data | st_da.bkptb_data);
    check_bit("lsiq_pop_vld", lsiq_pop_vld, ld_da.pop_vld | st_da.pop_vld);
    check_bit("lsiq_pop0_vld", lsiq_pop0_vld, ld_da.pop_vld);
    check_bit("lsiq_pop1_vld", lsiq_pop1_vld, st_da.pop_vld);
    check_vec("lsiq_pop_entry", lsiq_pop_entry, ld_da.pop_entry | st_da.pop_entry);
    check_vec("idu_wakeup", idu_wakeup,
              ref_wakeup(ld_rf, st_rf, ld_dc, st_dc, ld_da, st_da, depd_any));
    check_vec("idu_tlb_wakeup", idu_tlb_wakeup, mmu_tlb_wakeup);
    check_vec("idu_wait_old", idu_wait_old, ld_ag_wait_old | st_ag_wait_old | ld_da_wait_old);
    check_bit("lsu_no_op", lsu_no_op, ref_no_op(buf_empty));
    check_bit("lsu_had_no_op", lsu_had_no_op, ref_had_no_op(buf_empty));
  endtask

  // outputs are settled half a cycle after the driving edge
  always @(negedge cp0_lsu_clk)
    compare_outputs();

  task automatic check_regs_zero();
    check_sel("lsu_pfu_l1_dist_sel", lsu_pfu_l1_dist_sel, '0);
    check_sel("lsu_pfu_l2_dist_sel", lsu_pfu_l2_dist_sel, '0);
    check_evt("lsu_hpcp_evt", lsu_hpcp_evt, '0);
  endtask

  always @(posedge cp0_lsu_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
      report_failure($sformatf("timeout, run did not finish within %0d cycles", CYCLE_LIMIT));
  end

  initial
  begin
    cp0_lsu_clk = 1'b0;
    forever #4 cp0_lsu_clk = ~cp0_lsu_clk;
  end

  // ========================================================================
  // main sequence
  // ========================================================================
  initial
  begin
    hpcp_evt_t held_evt;
    void'($urandom(97368));
    cpurst_b = 1'b0;
    quiet_inputs();
    @(negedge cp0_lsu_clk);
    check_regs_zero();
    @(posedge cp0_lsu_clk);
    cpurst_b <= 1'b1;
    @(negedge cp0_lsu_clk);
    check_regs_zero();

    repeat (RANDOM_CYCLES)
    begin
      @(posedge cp0_lsu_clk);
      drive_random();
    end

    // prefetch sweep, select follows one cycle later and holds
    for (int n = 0; n < 4; n++)
    begin
      @(posedge cp0_lsu_clk);
      quiet_inputs();
      cp0_dcache_pref_dist <= PREF_DIST_W'(n);
      cp0_l2_pref_dist     <= PREF_DIST_W'(3 - n);
      @(posedge cp0_lsu_clk);
      repeat (3)
      begin
        @(negedge cp0_lsu_clk);
        check_sel("lsu_pfu_l1_dist_sel", lsu_pfu_l1_dist_sel, ref_dist_sel(PREF_DIST_W'(n)));
        check_sel("lsu_pfu_l2_dist_sel", lsu_pfu_l2_dist_sel, ref_dist_sel(PREF_DIST_W'(3 - n)));
      end
    end

    // every event with both unaligned flags, then counting off
    @(posedge cp0_lsu_clk);
    hpcp_cnt_en    <= 1'b1;
    ld_ag_inst_vld <= 1'b1;
    hpcp_raw       <= '1;
    lsu_has_fence  <= 1'b1;
    @(posedge cp0_lsu_clk);
    hpcp_cnt_en    <= 1'b0;
    hpcp_raw       <= '0;
    lsu_has_fence  <= 1'b0;
    held_evt = ref_hpcp_evt('1, 1'b1);
    repeat (4)
    begin
      @(negedge cp0_lsu_clk);
      check_evt("lsu_hpcp_evt", lsu_hpcp_evt, held_evt);
    end

    // stall_ori without sel gives no rf wakeup
    @(posedge cp0_lsu_clk);
    quiet_inputs();
    ld_rf <= '{sel: 1'b0, stall_ori: 1'b1, restart_entry: '1};
    st_rf <= '{sel: 1'b0, stall_ori: 1'b1, restart_entry: '1};
    @(negedge cp0_lsu_clk);
    check_vec("idu_wakeup", idu_wakeup, '0);
    @(posedge cp0_lsu_clk);
    ld_rf <= '{sel: 1'b1, stall_ori: 1'b1, restart_entry: '1};
    @(negedge cp0_lsu_clk);
    check_vec("idu_wakeup", idu_wakeup, '1);

    // wmb busy but with no outstanding op
    @(posedge cp0_lsu_clk);
    quiet_inputs();
    buf_empty <= '{wmb_empty: 1'b0, wmb_no_op: 1'b1, sq_empty: 1'b1, rb_empty: 1'b1,
                   lfb_empty: 1'b1, vmb_empty: 1'b1, vb_empty: 1'b1};
    @(negedge cp0_lsu_clk);
    check_bit("lsu_no_op", lsu_no_op, 1'b0);
    check_bit("lsu_had_no_op", lsu_had_no_op, 1'b1);

    @(negedge cp0_lsu_clk);
    if (error_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule
